/* source/isa_pkg.sv */
// rv32 isa definitions: alu functions, operand selects, store sizes, immediate decoders
package isa_pkg;

	localparam int xlen = 32;                  // data path width
	localparam logic [xlen-1:0] alu_bad_value = 32'hfacebeec; // unlisted alu function

	typedef logic [xlen-1:0] xlen_t;

	////////////////////////////////////////////////////////////////////////////
	// encodings
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_and  = 4'd2,
		alu_slt  = 4'd3,   // signed compare
		alu_sltu = 4'd4,   // unsigned compare
		alu_or   = 4'd5,
		alu_xor  = 4'd6,
		alu_srl  = 4'd7,
		alu_sll  = 4'd8,
		alu_sra  = 4'd9    // arithmetic right
	} alu_func_e;

	typedef enum logic [1:0] {
		opa_is_rs1  = 2'd0,
		opa_is_npc  = 2'd1,
		opa_is_pc   = 2'd2,
		opa_is_zero = 2'd3
	} opa_sel_e;

	typedef enum logic [2:0] {
		opb_is_rs2   = 3'd0,
		opb_is_i_imm = 3'd1,
		opb_is_s_imm = 3'd2,
		opb_is_b_imm = 3'd3,
		opb_is_u_imm = 3'd4,
		opb_is_j_imm = 3'd5   // 6 and 7 unused
	} opb_sel_e;

	typedef enum logic [1:0] {
		st_none = 2'd0,   // not a store
		st_byte = 2'd1,
		st_half = 2'd2,
		st_word = 2'd3
	} store_size_e;

	////////////////////////////////////////////////////////////////////////////
	// sign-extended immediates
	////////////////////////////////////////////////////////////////////////////

	function automatic xlen_t imm_i(input xlen_t inst);
		return {{20{inst[31]}}, inst[31:20]};
	endfunction

	function automatic xlen_t imm_s(input xlen_t inst);
		return {{20{inst[31]}}, inst[31:25], inst[11:7]};   // split field
	endfunction

	function automatic xlen_t imm_b(input xlen_t inst);
		return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	endfunction

	function automatic xlen_t imm_u(input xlen_t inst);
		return {inst[31:12], 12'b0};   // upper 20 bits, no extension needed
	endfunction

	function automatic xlen_t imm_j(input xlen_t inst);
		return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	endfunction

endpackage

/* source/fu_pkg.sv */
// functional unit tags and widths for rob, physical registers and store queue
package fu_pkg;

	localparam int pr_idx_w  = 6;   // 64 physical registers
	localparam int rob_idx_w = 5;   // 32 rob entries
	localparam int sq_idx_w  = 3;   // 8 store queue slots
	localparam int byte_en_w = 4;   // one enable per byte lane

	typedef logic [pr_idx_w-1:0]  pr_idx_t;
	typedef logic [rob_idx_w-1:0] rob_idx_t;
	typedef logic [sq_idx_w-1:0]  sq_idx_t;
	typedef logic [byte_en_w-1:0] byte_en_t;

	// what the complete bus sees
	typedef struct packed {
		isa_pkg::xlen_t dest_value;
		pr_idx_t        dest_pr;
		rob_idx_t       rob_entry;
		logic           halt;
	} complete_payload_t;

	// store queue entry fill
	typedef struct packed {
		isa_pkg::xlen_t addr;       // word aligned
		isa_pkg::xlen_t data;       // already in its byte lanes
		byte_en_t       usebytes;
		sq_idx_t        sq_idx;
	} store_payload_t;

endpackage

/* source/alu_exec.sv */
// integer alu: operand a/b selection and the ten rv32 alu functions
`timescale 1ns/1ps

module alu_exec (
	input  isa_pkg::opa_sel_e  opa_select,
	input  isa_pkg::opb_sel_e  opb_select,
	input  isa_pkg::alu_func_e alu_func,
	input  isa_pkg::xlen_t     inst,
	input  isa_pkg::xlen_t     pc,
	input  isa_pkg::xlen_t     npc,
	input  isa_pkg::xlen_t     r1_value,
	input  isa_pkg::xlen_t     r2_value,
	output isa_pkg::xlen_t     alu_result
);
	import isa_pkg::*;

	xlen_t opa;          // operand a mux out
	xlen_t opb;          // operand b mux out
	logic signed [xlen-1:0] opa_s;
	logic signed [xlen-1:0] opb_s;

	assign opa_s = opa;
	assign opb_s = opb;

	////////////////////////////////////////////////////////////////////////////
	// operand muxes
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (opa_select)
			opa_is_rs1:  opa = r1_value;
			opa_is_npc:  opa = npc;
			opa_is_pc:   opa = pc;
			default:     opa = '0;   // opa_is_zero
		endcase
	end

	always_comb begin
		case (opb_select)
			opb_is_rs2:   opb = r2_value;
			opb_is_i_imm: opb = imm_i(inst);
			opb_is_s_imm: opb = imm_s(inst);
			opb_is_b_imm: opb = imm_b(inst);
			opb_is_u_imm: opb = imm_u(inst);
			opb_is_j_imm: opb = imm_j(inst);
			default:      opb = '0;   // codes 6 and 7, flagged below
		endcase
	end

	// decoder only ever emits the six listed b selects
	always_comb begin
		if (!$isunknown(opb_select)) begin
			assert (opb_select inside {opb_is_rs2, opb_is_i_imm, opb_is_s_imm,
				opb_is_b_imm, opb_is_u_imm, opb_is_j_imm})
			else $error("alu_exec: illegal opb_select %0d", opb_select);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// alu
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (alu_func)
			alu_add:  alu_result = opa + opb;
			alu_sub:  alu_result = opa - opb;
			alu_and:  alu_result = opa & opb;
			alu_slt:  alu_result = xlen_t'(opa_s < opb_s);   // zero extended flag
			alu_sltu: alu_result = xlen_t'(opa < opb);
			alu_or:   alu_result = opa | opb;
			alu_xor:  alu_result = opa ^ opb;
			alu_srl:  alu_result = opa >> opb[4:0];          // shamt is low 5 bits
			alu_sll:  alu_result = opa << opb[4:0];
			alu_sra:  alu_result = xlen_t'(opa_s >>> opb[4:0]);
			default:  alu_result = alu_bad_value;            // shows up on a bad decode
		endcase
	end

endmodule

/* source/store_format.sv */
// store path: address adder, byte lane placement and byte enable mask
`timescale 1ns/1ps

module store_format (
	input  isa_pkg::store_size_e store_size,
	input  isa_pkg::xlen_t       inst,
	input  isa_pkg::xlen_t       r1_value,
	input  isa_pkg::xlen_t       r2_value,
	output isa_pkg::xlen_t       st_addr,
	output isa_pkg::xlen_t       st_data,
	output fu_pkg::byte_en_t     st_usebytes
);
	import isa_pkg::*;

	xlen_t      ea;        // effective address, unmasked
	logic [1:0] offset;    // byte offset inside the word

	assign ea      = r1_value + imm_s(inst);   // own adder, alu stays free
	assign offset  = ea[1:0];
	assign st_addr = {ea[xlen-1:2], 2'b00};

	always_comb begin
		st_data     = '0;
		st_usebytes = '0;
		case (store_size)
			st_byte: begin
				st_usebytes = 4'b0001 << offset;
				st_data     = xlen_t'(r2_value[7:0]) << {offset, 3'b000};   // 8*offset
			end
			st_half: begin
				case (offset)
					2'b00: begin
						st_usebytes    = 4'b0011;
						st_data[15:0]  = r2_value[15:0];
					end
					2'b10: begin
						st_usebytes    = 4'b1100;
						st_data[31:16] = r2_value[15:0];
					end
					default: ;   // odd offset, nothing written
				endcase
			end
			st_word: begin
				if (offset == 2'b00) begin
					st_usebytes = 4'b1111;
					st_data     = r2_value;
				end
			end
			default: ;   // st_none
		endcase
	end

	// only single lanes, aligned halves, full words or nothing
	always_comb begin
		if (!$isunknown(st_usebytes)) begin
			assert (st_usebytes inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
				4'b0011, 4'b1100, 4'b1111})
			else $error("store_format: bad byte mask %b", st_usebytes);
		end
	end

endmodule

/* source/stage_hold_reg.sv */
// valid tagged payload register that holds under stall, payload type is a parameter
`timescale 1ns/1ps

module stage_hold_reg #(
	parameter type payload_t = isa_pkg::xlen_t
) (
	input  logic     clock,
	input  logic     arst_n,
	input  logic     load,      // capture d, wins over clear
	input  logic     clear,     // entry leaves
	input  payload_t d,
	output payload_t q,
	output logic     q_valid
);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			q_valid <= 1'b0;
		end else if (load) begin
			q_valid <= 1'b1;
		end else if (clear) begin
			q_valid <= 1'b0;
		end
	end

	// payload only, valid bit qualifies it
	always_ff @(posedge clock) begin
		if (load) q <= d;
	end

	// held entry must not drift between edges
	a_hold_stable: assert property (@(posedge clock) disable iff (!arst_n)
		(q_valid && !load && !clear) |=> $stable(q))
	else $error("stage_hold_reg: payload changed while held");

endmodule

/* source/complete_stage.sv */
// complete stage that registers alu and store results side by side and drives fu_ready
`timescale 1ns/1ps

module complete_stage (
	input  logic                 clock,
	input  logic                 arst_n,
	input  logic                 valid,
	input  isa_pkg::store_size_e store_size,
	input  logic                 complete_stall,   // complete bus busy
	input  isa_pkg::xlen_t       alu_result,
	input  isa_pkg::xlen_t       st_addr,
	input  isa_pkg::xlen_t       st_data,
	input  fu_pkg::byte_en_t     st_usebytes,
	input  fu_pkg::pr_idx_t      dest_pr,
	input  fu_pkg::rob_idx_t     rob_entry,
	input  fu_pkg::sq_idx_t      sq_tail,
	input  logic                 halt,
	output logic                 fu_ready,
	output logic                 want_to_complete,
	output isa_pkg::xlen_t       dest_value,
	output fu_pkg::pr_idx_t      dest_pr_out,
	output fu_pkg::rob_idx_t     rob_entry_out,
	output logic                 halt_out,
	output logic                 if_take_branch,
	output isa_pkg::xlen_t       target_pc,
	output logic                 if_store,
	output isa_pkg::xlen_t       store_addr,
	output isa_pkg::xlen_t       store_data,
	output fu_pkg::byte_en_t     store_usebytes,
	output fu_pkg::sq_idx_t      sq_idx
);
	import isa_pkg::*;
	import fu_pkg::*;

	complete_payload_t c_d, c_q;
	store_payload_t    s_d, s_q;
	logic              accept;     // slot taken this edge
	logic              is_store;
	logic              leave;      // held entries go out

	assign is_store = (store_size != st_none);
	assign fu_ready = !(want_to_complete && complete_stall);   // one entry deep
	assign accept   = valid && fu_ready;
	assign leave    = !complete_stall;

	// a store reuses the completion slot and puts its address on the bus
	assign c_d = '{dest_value: is_store ? st_addr : alu_result,
		dest_pr: dest_pr, rob_entry: rob_entry, halt: halt};
	assign s_d = '{addr: st_addr, data: st_data, usebytes: st_usebytes, sq_idx: sq_tail};

	stage_hold_reg #(.payload_t(complete_payload_t)) u_complete_reg (
		.clock   (clock),
		.arst_n  (arst_n),
		.load    (accept),
		.clear   (leave),
		.d       (c_d),
		.q       (c_q),
		.q_valid (want_to_complete)
	);

	stage_hold_reg #(.payload_t(store_payload_t)) u_store_reg (
		.clock   (clock),
		.arst_n  (arst_n),
		.load    (accept && is_store),
		.clear   ((accept && !is_store) || leave),   // non-store slot replaces it
		.d       (s_d),
		.q       (s_q),
		.q_valid (if_store)
	);

	assign dest_value     = c_q.dest_value;
	assign dest_pr_out    = c_q.dest_pr;
	assign rob_entry_out  = c_q.rob_entry;
	assign halt_out       = c_q.halt;
	assign if_take_branch = 1'b0;   // no branch resolution here
	assign target_pc      = '0;
	assign store_addr     = s_q.addr;
	assign store_data     = s_q.data;
	assign store_usebytes = s_q.usebytes;
	assign sq_idx         = s_q.sq_idx;

	// issuer keeps an offered slot until the unit takes it
	a_slot_held: assert property (@(posedge clock) disable iff (!arst_n)
		(valid && !fu_ready) |=> (valid && $stable(store_size) && $stable(c_d) && $stable(s_d)))
	else $error("complete_stage: issue slot changed while fu_ready was low");

endmodule

/* source/fu_alu.sv */
// alu functional unit top: execute and store paths feeding the complete stage
`timescale 1ns/1ps

module fu_alu (
	input  logic                 clock,
	input  logic                 arst_n,
	input  logic                 complete_stall,
	// issue slot
	input  logic                 valid,
	input  isa_pkg::alu_func_e   alu_func,
	input  isa_pkg::opa_sel_e    opa_select,
	input  isa_pkg::opb_sel_e    opb_select,
	input  isa_pkg::store_size_e store_size,
	input  isa_pkg::xlen_t       inst,
	input  isa_pkg::xlen_t       pc,
	input  isa_pkg::xlen_t       npc,
	input  isa_pkg::xlen_t       r1_value,
	input  isa_pkg::xlen_t       r2_value,
	input  fu_pkg::pr_idx_t      dest_pr,
	input  fu_pkg::rob_idx_t     rob_entry,
	input  fu_pkg::sq_idx_t      sq_tail,
	input  logic                 halt,
	// complete bus and store queue
	output logic                 fu_ready,
	output logic                 want_to_complete,
	output isa_pkg::xlen_t       dest_value,
	output fu_pkg::pr_idx_t      dest_pr_out,
	output fu_pkg::rob_idx_t     rob_entry_out,
	output logic                 halt_out,
	output logic                 if_take_branch,
	output isa_pkg::xlen_t       target_pc,
	output logic                 if_store,
	output isa_pkg::xlen_t       store_addr,
	output isa_pkg::xlen_t       store_data,
	output fu_pkg::byte_en_t     store_usebytes,
	output fu_pkg::sq_idx_t      sq_idx
);
	import isa_pkg::*;
	import fu_pkg::*;

	xlen_t    alu_result;
	xlen_t    st_addr, st_data;
	byte_en_t st_usebytes;

	alu_exec u_alu_exec (
		.opa_select (opa_select),
		.opb_select (opb_select),
		.alu_func   (alu_func),
		.inst       (inst),
		.pc         (pc),
		.npc        (npc),
		.r1_value   (r1_value),
		.r2_value   (r2_value),
		.alu_result (alu_result)
	);

	store_format u_store_format (   // runs beside the alu every cycle
		.store_size  (store_size),
		.inst        (inst),
		.r1_value    (r1_value),
		.r2_value    (r2_value),
		.st_addr     (st_addr),
		.st_data     (st_data),
		.st_usebytes (st_usebytes)
	);

	complete_stage u_complete_stage (
		.clock            (clock),
		.arst_n           (arst_n),
		.valid            (valid),
		.store_size       (store_size),
		.complete_stall   (complete_stall),
		.alu_result       (alu_result),
		.st_addr          (st_addr),
		.st_data          (st_data),
		.st_usebytes      (st_usebytes),
		.dest_pr          (dest_pr),
		.rob_entry        (rob_entry),
		.sq_tail          (sq_tail),
		.halt             (halt),
		.fu_ready         (fu_ready),
		.want_to_complete (want_to_complete),
		.dest_value       (dest_value),
		.dest_pr_out      (dest_pr_out),
		.rob_entry_out    (rob_entry_out),
		.halt_out         (halt_out),
		.if_take_branch   (if_take_branch),
		.target_pc        (target_pc),
		.if_store         (if_store),
		.store_addr       (store_addr),
		.store_data       (store_data),
		.store_usebytes   (store_usebytes),
		.sq_idx           (sq_idx)
	);

endmodule

/* verif/fu_alu_tb.sv */
// directed testbench for the alu functional unit, checked against a reference model
`timescale 1ns/1ps

module fu_alu_tb;
	import isa_pkg::*;
	import fu_pkg::*;

	localparam int alu_reps   = 4;   // random operand pairs per function
	localparam int sel_reps   = 4;   // passes over the operand selects
	localparam int store_reps = 2;   // passes over the store cases
	localparam int num_slots  = 10 * (alu_reps + 3) + 8 * sel_reps + 9 * store_reps;
	localparam int max_cycles = 2 * num_slots + 60;   // two cycles a slot, plus reset and stall

	// edge operands: sign bits, shift by 31
	localparam xlen_t edge_a [3] = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff};
	localparam xlen_t edge_b [3] = '{32'd31, 32'h8000_0000, 32'd1};

	logic          clock;
	logic          arst_n;
	logic          complete_stall;
	logic          valid;
	alu_func_e     alu_func;
	opa_sel_e      opa_select;
	opb_sel_e      opb_select;
	store_size_e   store_size;
	xlen_t         inst;
	xlen_t         pc;
	xlen_t         npc;
	xlen_t         r1_value;
	xlen_t         r2_value;
	pr_idx_t       dest_pr;
	rob_idx_t      rob_entry;
	sq_idx_t       sq_tail;
	logic          halt;
	logic          fu_ready;
	logic          want_to_complete;
	xlen_t         dest_value;
	pr_idx_t       dest_pr_out;
	rob_idx_t      rob_entry_out;
	logic          halt_out;
	logic          if_take_branch;
	xlen_t         target_pc;
	logic          if_store;
	xlen_t         store_addr;
	xlen_t         store_data;
	byte_en_t      store_usebytes;
	sq_idx_t       sq_idx;
	int            cycle_count = 0;

	fu_alu u_dut (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;   // 100 ns period
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("Testbench failed");
			$fatal(1, "hang");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic xlen_t model_imm(input opb_sel_e sel, input xlen_t i);
		case (sel)
			opb_is_i_imm: return {{20{i[31]}}, i[31:20]};
			opb_is_s_imm: return {{20{i[31]}}, i[31:25], i[11:7]};
			opb_is_b_imm: return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
			opb_is_u_imm: return {i[31:12], 12'h000};
			opb_is_j_imm: return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
			default:      return '0;
		endcase
	endfunction

	function automatic xlen_t model_alu(input alu_func_e f, input xlen_t a, input xlen_t b);
		case (f)
			alu_add:  return a + b;
			alu_sub:  return a - b;
			alu_and:  return a & b;
			alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			alu_sltu: return (a < b) ? 32'd1 : 32'd0;
			alu_or:   return a | b;
			alu_xor:  return a ^ b;
			alu_srl:  return a >> b[4:0];
			alu_sll:  return a << b[4:0];
			alu_sra:  return xlen_t'($signed(a) >>> b[4:0]);
			default:  return 32'hfacebeec;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		$display("[ERROR] %s: expected %h, actual %h", what, exp, act);
		$display("Testbench failed");
		$fatal(1, "value mismatch");
	endtask

	task automatic check_word(input string what, input xlen_t exp, input xlen_t act);
		if (act !== exp) report_mismatch(what, exp, act);
	endtask

	task automatic check_bytes(input string what, input byte_en_t exp, input byte_en_t act);
		if (act !== exp) report_mismatch(what, 32'(exp), 32'(act));
	endtask

	task automatic check_pr(input string what, input pr_idx_t exp, input pr_idx_t act);
		if (act !== exp) report_mismatch(what, 32'(exp), 32'(act));
	endtask

	task automatic check_rob(input string what, input rob_idx_t exp, input rob_idx_t act);
		if (act !== exp) report_mismatch(what, 32'(exp), 32'(act));
	endtask

	task automatic check_sq(input string what, input sq_idx_t exp, input sq_idx_t act);
		if (act !== exp) report_mismatch(what, 32'(exp), 32'(act));
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) report_mismatch(what, 32'(exp), 32'(act));
	endtask

	// full output bundle against one expected entry
	task automatic check_outputs(input string name, input complete_payload_t c,
			input store_payload_t s, input logic st, input logic ready);
		check_bit({name, "/fu_ready"}, ready, fu_ready);
		check_bit({name, "/want_to_complete"}, 1'b1, want_to_complete);
		check_word({name, "/dest_value"}, c.dest_value, dest_value);
		check_pr({name, "/dest_pr_out"}, c.dest_pr, dest_pr_out);
		check_rob({name, "/rob_entry_out"}, c.rob_entry, rob_entry_out);
		check_bit({name, "/halt_out"}, c.halt, halt_out);
		check_bit({name, "/if_take_branch"}, 1'b0, if_take_branch);
		check_word({name, "/target_pc"}, 32'h0, target_pc);
		check_bit({name, "/if_store"}, st, if_store);
		if (st) begin
			check_word({name, "/store_addr"}, s.addr, store_addr);
			check_word({name, "/store_data"}, s.data, store_data);
			check_bytes({name, "/store_usebytes"}, s.usebytes, store_usebytes);
			check_sq({name, "/sq_idx"}, s.sq_idx, sq_idx);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// slot drivers
	////////////////////////////////////////////////////////////////////////////

	// call right after a rising edge; returns what the slot must produce
	task automatic drive_slot(input alu_func_e f, input opa_sel_e a_sel, input opb_sel_e b_sel,
			input store_size_e size, input xlen_t i_word, input xlen_t r1, input xlen_t r2,
			output complete_payload_t c, output store_payload_t s, output logic st);
		xlen_t    pc_v;
		xlen_t    a;
		xlen_t    b;
		xlen_t    ea;
		xlen_t    data_v;
		byte_en_t be_v;
		pc_v = xlen_t'($urandom) & ~32'h3;
		case (a_sel)
			opa_is_rs1: a = r1;
			opa_is_npc: a = pc_v + 32'd4;
			opa_is_pc:  a = pc_v;
			default:    a = '0;
		endcase
		b = (b_sel == opb_is_rs2) ? r2 : model_imm(b_sel, i_word);
		ea = r1 + model_imm(opb_is_s_imm, i_word);   // effective store address
		data_v = '0;
		be_v = '0;
		case (size)
			st_byte: begin
				be_v[ea[1:0]] = 1'b1;
				data_v[{ea[1:0], 3'b000} +: 8] = r2[7:0];
			end
			st_half: begin
				if (!ea[0]) begin   // odd halfword writes nothing
					be_v[ea[1:0] +: 2] = 2'b11;
					data_v[{ea[1:0], 3'b000} +: 16] = r2[15:0];
				end
			end
			st_word: begin
				if (ea[1:0] == 2'b00) begin
					be_v = 4'b1111;
					data_v = r2;
				end
			end
			default: ;
		endcase
		s.addr = ea & ~32'h3;
		s.data = data_v;
		s.usebytes = be_v;
		s.sq_idx = sq_idx_t'($urandom);
		st = (size != st_none);
		c.dest_value = st ? s.addr : model_alu(f, a, b);   // store puts its address on the bus
		c.dest_pr = pr_idx_t'($urandom);
		c.rob_entry = rob_idx_t'($urandom);
		c.halt = 1'($urandom);
		valid      <= 1'b1;
		alu_func   <= f;
		opa_select <= a_sel;
		opb_select <= b_sel;
		store_size <= size;
		inst       <= i_word;
		pc         <= pc_v;
		npc        <= pc_v + 32'd4;
		r1_value   <= r1;
		r2_value   <= r2;
		dest_pr    <= c.dest_pr;
		rob_entry  <= c.rob_entry;
		sq_tail    <= s.sq_idx;
		halt       <= c.halt;
	endtask

	// one slot, checked one cycle after the accepting edge
	task automatic exec_slot(input string name, input alu_func_e f, input opa_sel_e a_sel,
			input opb_sel_e b_sel, input store_size_e size, input xlen_t i_word,
			input xlen_t r1, input xlen_t r2);
		complete_payload_t c;
		store_payload_t    s;
		logic              st;
		@(posedge clock);
		drive_slot(f, a_sel, b_sel, size, i_word, r1, r2, c, s, st);
		@(posedge clock);   // dut takes it here
		valid <= 1'b0;
		@(negedge clock);
		check_outputs(name, c, s, st, 1'b1);
	endtask

	// store with the low two address bits forced to off
	task automatic store_slot(input string name, input store_size_e size, input int off);
		xlen_t i_word;
		xlen_t r1;
		i_word = xlen_t'($urandom);
		r1 = (xlen_t'($urandom) & ~32'h3) + xlen_t'(off) - model_imm(opb_is_s_imm, i_word);
		exec_slot($sformatf("%s_off%0d", name, off), alu_add, opa_is_rs1, opb_is_s_imm, size,
			i_word, r1, xlen_t'($urandom));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset();
		@(negedge clock);
		check_bit("reset/want_to_complete", 1'b0, want_to_complete);
		check_bit("reset/if_store", 1'b0, if_store);
		check_bit("reset/fu_ready", 1'b1, fu_ready);
	endtask

	task automatic test_alu_funcs();
		for (int f = 0; f < 10; f++) begin
			for (int k = 0; k < alu_reps; k++) begin
				exec_slot($sformatf("alu_%0d_rand", f), alu_func_e'(f), opa_is_rs1, opb_is_rs2,
					st_none, xlen_t'($urandom), xlen_t'($urandom), xlen_t'($urandom));
			end
			for (int k = 0; k < 3; k++) begin
				exec_slot($sformatf("alu_%0d_edge%0d", f, k), alu_func_e'(f), opa_is_rs1,
					opb_is_rs2, st_none, xlen_t'($urandom), edge_a[k], edge_b[k]);
			end
		end
	endtask

	task automatic test_operand_selects();
		for (int k = 0; k < sel_reps; k++) begin
			for (int a = 1; a < 4; a++) begin   // npc, pc, zero
				exec_slot($sformatf("opa_%0d", a), alu_add, opa_sel_e'(a), opb_is_rs2, st_none,
					xlen_t'($urandom), xlen_t'($urandom), xlen_t'($urandom));
			end
			for (int b = 1; b < 6; b++) begin   // i, s, b, u, j immediates
				exec_slot($sformatf("opb_%0d", b), alu_add, opa_is_rs1, opb_sel_e'(b), st_none,
					xlen_t'($urandom), xlen_t'($urandom), xlen_t'($urandom));
			end
		end
	endtask

	task automatic test_stores();
		for (int k = 0; k < store_reps; k++) begin
			for (int off = 0; off < 4; off++) begin
				store_slot("store_byte", st_byte, off);
			end
			store_slot("store_half", st_half, 0);
			store_slot("store_half", st_half, 2);
			store_slot("store_half", st_half, 1);   // odd, empty mask
			store_slot("store_word", st_word, 0);
			store_slot("store_word", st_word, 3);   // misaligned, empty mask
		end
	endtask

	// a store is held under stall, the next alu slot waits
	task automatic test_stall();
		complete_payload_t ca;
		complete_payload_t cb;
		store_payload_t    sa;
		store_payload_t    sb;
		logic              sta;
		logic              stb;
		@(posedge clock);
		drive_slot(alu_add, opa_is_rs1, opb_is_s_imm, st_byte, xlen_t'($urandom),
			xlen_t'($urandom), xlen_t'($urandom), ca, sa, sta);
		complete_stall <= 1'b1;   // bus busy as the store lands
		@(posedge clock);
		drive_slot(alu_sub, opa_is_rs1, opb_is_rs2, st_none, xlen_t'($urandom),
			xlen_t'($urandom), xlen_t'($urandom), cb, sb, stb);
		repeat (3) begin
			@(negedge clock);
			check_outputs("stall_hold", ca, sa, sta, 1'b0);
			@(posedge clock);
		end
		complete_stall <= 1'b0;
		@(negedge clock);
		check_outputs("stall_drop", ca, sa, sta, 1'b1);   // still held, ready again
		@(posedge clock);   // waiting slot taken
		valid <= 1'b0;
		@(negedge clock);
		check_outputs("stall_release", cb, sb, stb, 1'b1);
	endtask

	initial begin
		void'($urandom(45261));   // single seed for the run
		arst_n         = 1'b0;
		complete_stall = 1'b0;
		valid          = 1'b0;
		alu_func       = alu_add;
		opa_select     = opa_is_rs1;
		opb_select     = opb_is_rs2;
		store_size     = st_none;
		inst           = '0;
		pc             = '0;
		npc            = '0;
		r1_value       = '0;
		r2_value       = '0;
		dest_pr        = '0;
		rob_entry      = '0;
		sq_tail        = '0;
		halt           = 1'b0;
		repeat (4) @(posedge clock);
		arst_n <= 1'b1;
		test_reset();
		test_alu_funcs();
		test_operand_selects();
		test_stores();
		test_stall();
		$display("Testbench passed");
		$finish;
	end

endmodule

/* flist.f */
source/isa_pkg.sv
source/fu_pkg.sv
source/alu_exec.sv
source/store_format.sv
source/stage_hold_reg.sv
source/complete_stage.sv
source/fu_alu.sv
verif/fu_alu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fu_alu_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter %.sv %.v,$(shell cat $(FLIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
